/* logic/rv_pkg.sv */
package rv_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;
  localparam logic [XLEN-1:0] PC_STEP = 32'd4;

  // major opcodes, bits 6:0 of every 32-bit instruction
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef struct packed {
    logic [6:0]            funct7;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_r_t;

  typedef struct packed {
    logic [11:0]           imm;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_i_t;

  typedef struct packed {
    logic [6:0]            imm_11_5;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [4:0]            imm_4_0;
    logic [6:0]            opcode;
  } instr_s_t;

  typedef struct packed {
    logic                  imm_12;
    logic [5:0]            imm_10_5;
    logic [REG_ADDR_W-1:0] rs2;
    logic [REG_ADDR_W-1:0] rs1;
    logic [2:0]            funct3;
    logic [3:0]            imm_4_1;
    logic                  imm_11;
    logic [6:0]            opcode;
  } instr_b_t;

  typedef struct packed {
    logic [19:0]           imm_31_12;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_u_t;

  typedef struct packed {
    logic                  imm_20;
    logic [9:0]            imm_10_1;
    logic                  imm_11;
    logic [7:0]            imm_19_12;
    logic [REG_ADDR_W-1:0] rd;
    logic [6:0]            opcode;
  } instr_j_t;

  // one fetched word, read through whichever format applies
  typedef union packed {
    instr_r_t r;
    instr_i_t i;
    instr_s_t s;
    instr_b_t b;
    instr_u_t u;
    instr_j_t j;
  } instr_t;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // encoded as funct3[1:0] of loads and stores
  typedef enum logic [1:0] {
    mem_byte = 2'b00,
    mem_half = 2'b01,
    mem_word = 2'b10
  } mem_size_e;

  typedef struct packed {
    logic [REG_ADDR_W-1:0] rd;
    logic [REG_ADDR_W-1:0] rs1;
    logic [REG_ADDR_W-1:0] rs2;
    logic [XLEN-1:0]       imm;
    alu_op_e               alu_op;
    logic                  use_imm;
    logic                  use_pc;
    logic                  is_branch;
    logic                  is_jal;
    logic                  is_jalr;
    logic                  is_load;
    logic                  is_store;
    logic                  writes_rd;
    logic [2:0]            funct3;
    mem_size_e             mem_size;
    logic                  load_unsigned;
    logic                  valid;
  } decode_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic [XLEN-1:0] next_pc;
    logic            taken;
    logic            misaligned;
  } exec_t;

  typedef struct packed {
    logic [XLEN-1:0]   addr;
    logic [XLEN-1:0]   wdata;
    logic [XLEN/8-1:0] wstrb;
    logic              misaligned;
  } lsu_req_t;

endpackage

/* logic/rv_decode.sv */
`timescale 1ns/10ps

module rv_decode (
  input  rv_pkg::instr_t  instr,
  output rv_pkg::decode_t dec
);

  logic [rv_pkg::XLEN-1:0] imm_i;
  logic [rv_pkg::XLEN-1:0] imm_s;
  logic [rv_pkg::XLEN-1:0] imm_b;
  logic [rv_pkg::XLEN-1:0] imm_u;
  logic [rv_pkg::XLEN-1:0] imm_j;
  logic [2:0] f3;
  logic funct7_zero;
  logic funct7_alt;

  function automatic rv_pkg::alu_op_e alu_from_funct3(input logic [2:0] funct3,
                                                      input logic alt);
    case (funct3)
      3'b000:  return alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      3'b001:  return rv_pkg::alu_sll;
      3'b010:  return rv_pkg::alu_slt;
      3'b011:  return rv_pkg::alu_sltu;
      3'b100:  return rv_pkg::alu_xor;
      3'b101:  return alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      3'b110:  return rv_pkg::alu_or;
      default: return rv_pkg::alu_and;
    endcase
  endfunction

  assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
  assign imm_s = {{20{instr.s.imm_11_5[6]}}, instr.s.imm_11_5, instr.s.imm_4_0};
  assign imm_b = {{19{instr.b.imm_12}}, instr.b.imm_12, instr.b.imm_11, instr.b.imm_10_5,
                  instr.b.imm_4_1, 1'b0};
  assign imm_u = {instr.u.imm_31_12, 12'b0};
  assign imm_j = {{11{instr.j.imm_20}}, instr.j.imm_20, instr.j.imm_19_12, instr.j.imm_11,
                  instr.j.imm_10_1, 1'b0};

  assign f3 = instr.r.funct3;
  assign funct7_zero = instr.r.funct7 == 7'b0000000;
  assign funct7_alt = instr.r.funct7 == 7'b0100000;

  always_comb begin
    dec = '0;
    dec.rd = instr.r.rd;
    dec.rs1 = instr.r.rs1;
    dec.rs2 = instr.r.rs2;
    dec.funct3 = f3;
    dec.alu_op = rv_pkg::alu_add;
    dec.mem_size = rv_pkg::mem_size_e'(f3[1:0]);
    dec.load_unsigned = f3[2];
    case (instr.r.opcode)
      rv_pkg::OPC_LUI: begin
        dec.imm = imm_u;
        dec.alu_op = rv_pkg::alu_pass_b;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      rv_pkg::OPC_AUIPC: begin
        dec.imm = imm_u;
        dec.use_imm = 1'b1;
        dec.use_pc = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      rv_pkg::OPC_JAL: begin
        dec.imm = imm_j;
        dec.is_jal = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = 1'b1;
      end
      rv_pkg::OPC_JALR: begin
        dec.imm = imm_i;
        dec.is_jalr = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = f3 == 3'b000;
      end
      rv_pkg::OPC_BRANCH: begin
        dec.imm = imm_b;
        dec.is_branch = 1'b1;
        dec.valid = f3[2:1] != 2'b01;
      end
      rv_pkg::OPC_LOAD: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.is_load = 1'b1;
        dec.writes_rd = 1'b1;
        dec.valid = f3 != 3'b011 && f3[2:1] != 2'b11;
      end
      rv_pkg::OPC_STORE: begin
        dec.imm = imm_s;
        dec.use_imm = 1'b1;
        dec.is_store = 1'b1;
        dec.valid = !f3[2] && f3[1:0] != 2'b11;
      end
      rv_pkg::OPC_OP_IMM: begin
        dec.imm = imm_i;
        dec.use_imm = 1'b1;
        dec.writes_rd = 1'b1;
        // only srai borrows funct7, the other immediates use all twelve bits
        dec.alu_op = alu_from_funct3(f3, funct7_alt && f3 == 3'b101);
        if (f3 == 3'b001) begin
          dec.valid = funct7_zero;
        end else if (f3 == 3'b101) begin
          dec.valid = funct7_zero || funct7_alt;
        end else begin
          dec.valid = 1'b1;
        end
      end
      rv_pkg::OPC_OP: begin
        dec.writes_rd = 1'b1;
        dec.alu_op = alu_from_funct3(f3, funct7_alt);
        dec.valid = funct7_zero || (funct7_alt && (f3 == 3'b000 || f3 == 3'b101));
      end
      // ecall, ebreak and csr access all end in the trap
      rv_pkg::OPC_SYSTEM: begin
        dec.valid = 1'b0;
      end
      default: begin
        dec.valid = 1'b0;
      end
    endcase
  end

endmodule

/* logic/rv_alu.sv */
`timescale 1ns/10ps

module rv_alu (
  input  rv_pkg::decode_t         dec,
  input  logic [rv_pkg::XLEN-1:0] pc,
  input  logic [rv_pkg::XLEN-1:0] rs1_data,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  output rv_pkg::exec_t           ex
);

  logic [rv_pkg::XLEN-1:0] op_a;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_out;
  logic [rv_pkg::XLEN-1:0] pc_link;
  logic [rv_pkg::XLEN-1:0] jalr_sum;
  logic [rv_pkg::XLEN-1:0] target;
  logic [4:0] shamt;
  logic cond;
  logic taken;

  assign op_a = dec.use_pc ? pc : rs1_data;
  assign op_b = dec.use_imm ? dec.imm : rs2_data;
  // the immediate carries shamt in its low bits
  assign shamt = op_b[4:0];

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_sub:  alu_out = op_a - op_b;
      rv_pkg::alu_sll:  alu_out = op_a << shamt;
      rv_pkg::alu_slt:  alu_out = {{(rv_pkg::XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      rv_pkg::alu_sltu: alu_out = {{(rv_pkg::XLEN-1){1'b0}}, op_a < op_b};
      rv_pkg::alu_xor:  alu_out = op_a ^ op_b;
      rv_pkg::alu_srl:  alu_out = op_a >> shamt;
      rv_pkg::alu_sra:  alu_out = $signed(op_a) >>> shamt;
      rv_pkg::alu_or:   alu_out = op_a | op_b;
      rv_pkg::alu_and:  alu_out = op_a & op_b;
      rv_pkg::alu_pass_b: alu_out = op_b;
      default:          alu_out = op_a + op_b;
    endcase
  end

  always_comb begin
    case (dec.funct3)
      3'b000:  cond = rs1_data == rs2_data;
      3'b001:  cond = rs1_data != rs2_data;
      3'b100:  cond = $signed(rs1_data) < $signed(rs2_data);
      3'b101:  cond = $signed(rs1_data) >= $signed(rs2_data);
      3'b110:  cond = rs1_data < rs2_data;
      default: cond = rs1_data >= rs2_data;
    endcase
  end

  assign pc_link = pc + rv_pkg::PC_STEP;
  assign jalr_sum = rs1_data + dec.imm;
  assign target = dec.is_jalr ? {jalr_sum[rv_pkg::XLEN-1:1], 1'b0} : pc + dec.imm;
  assign taken = dec.is_jal || dec.is_jalr || (dec.is_branch && cond);

  assign ex.result = (dec.is_jal || dec.is_jalr) ? pc_link : alu_out;
  assign ex.next_pc = taken ? target : pc_link;
  assign ex.taken = taken;
  // without compressed instructions every target must be word aligned
  assign ex.misaligned = taken && target[1];

endmodule

/* logic/rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
  input  logic                          clk,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [rv_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic                          we,
  input  logic [rv_pkg::XLEN-1:0]       wdata,
  output logic [rv_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_pkg::XLEN-1:0]       rs2_data
);

  logic [rv_pkg::XLEN-1:0] regs [2**rv_pkg::REG_ADDR_W];

  always_ff @(posedge clk) begin
    if (we && rd_addr != '0) begin
      regs[rd_addr] <= wdata;
    end
  end

  // x0 is hardwired, its storage entry is never written
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* logic/rv_lsu.sv */
`timescale 1ns/10ps

module rv_lsu (
  input  rv_pkg::decode_t         dec,
  input  logic [rv_pkg::XLEN-1:0] addr,
  input  logic [rv_pkg::XLEN-1:0] rs2_data,
  input  logic [rv_pkg::XLEN-1:0] mem_rdata,
  output rv_pkg::lsu_req_t        req,
  output logic [rv_pkg::XLEN-1:0] load_data
);

  logic [1:0] offset;
  logic [rv_pkg::XLEN-1:0] lane_data;
  logic [rv_pkg::XLEN/8-1:0] strb;
  logic [rv_pkg::XLEN-1:0] shifted;
  logic misaligned;

  assign offset = addr[1:0];

  // store data is copied to every lane, the strobe picks the live bytes
  always_comb begin
    case (dec.mem_size)
      rv_pkg::mem_byte: begin
        lane_data = {4{rs2_data[7:0]}};
        strb = 4'b0001 << offset;
        misaligned = 1'b0;
      end
      rv_pkg::mem_half: begin
        lane_data = {2{rs2_data[15:0]}};
        strb = offset[1] ? 4'b1100 : 4'b0011;
        misaligned = offset[0];
      end
      default: begin
        lane_data = rs2_data;
        strb = 4'b1111;
        misaligned = offset != 2'b00;
      end
    endcase
  end

  assign req.addr = {addr[rv_pkg::XLEN-1:2], 2'b00};
  assign req.wdata = lane_data;
  assign req.wstrb = dec.is_store ? strb : '0;
  assign req.misaligned = (dec.is_load || dec.is_store) && misaligned;

  // bring the addressed lane down to bit 0
  assign shifted = mem_rdata >> {offset, 3'b000};

  always_comb begin
    case (dec.mem_size)
      rv_pkg::mem_byte: begin
        load_data = {{24{!dec.load_unsigned && shifted[7]}}, shifted[7:0]};
      end
      rv_pkg::mem_half: begin
        load_data = {{16{!dec.load_unsigned && shifted[15]}}, shifted[15:0]};
      end
      default: begin
        load_data = mem_rdata;
      end
    endcase
  end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/10ps

module rv_core (
  input  logic                        clk,
  input  logic                        reset,
  output logic                        mem_valid,
  output logic                        mem_instr,
  input  logic                        mem_ready,
  output logic [rv_pkg::XLEN-1:0]     mem_addr,
  output logic [rv_pkg::XLEN-1:0]     mem_wdata,
  output logic [rv_pkg::XLEN/8-1:0]   mem_wstrb,
  input  logic [rv_pkg::XLEN-1:0]     mem_rdata,
  output logic                        trap
);

  typedef enum logic [2:0] {
    st_fetch, st_fetch_wait, st_decode, st_execute, st_mem, st_write_back, st_trap
  } state_e;

  state_e state;
  logic [rv_pkg::XLEN-1:0] pc;
  rv_pkg::instr_t instr_q;
  rv_pkg::decode_t dec;
  rv_pkg::decode_t dec_q;
  rv_pkg::exec_t ex;
  rv_pkg::lsu_req_t req;
  logic [rv_pkg::XLEN-1:0] rs1_data;
  logic [rv_pkg::XLEN-1:0] rs2_data;
  logic [rv_pkg::XLEN-1:0] load_data;
  logic [rv_pkg::XLEN-1:0] result_q;
  logic is_mem;
  logic fault;
  logic rf_we;

  rv_decode u_decode (
    .instr (instr_q),
    .dec   (dec)
  );

  rv_alu u_alu (
    .dec      (dec_q),
    .pc       (pc),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .ex       (ex)
  );

  rv_lsu u_lsu (
    .dec       (dec_q),
    .addr      (ex.result),
    .rs2_data  (rs2_data),
    .mem_rdata (mem_rdata),
    .req       (req),
    .load_data (load_data)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rs1_addr (dec_q.rs1),
    .rs2_addr (dec_q.rs2),
    .rd_addr  (dec_q.rd),
    .we       (rf_we),
    .wdata    (result_q),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  assign is_mem = dec_q.is_load || dec_q.is_store;
  assign fault = !dec_q.valid || ex.misaligned || req.misaligned;
  assign rf_we = state == st_write_back && dec_q.writes_rd;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_fetch;
      pc <= '0;
      trap <= 1'b0;
      mem_valid <= 1'b0;
      mem_instr <= 1'b0;
      mem_wstrb <= '0;
    end else begin
      case (state)
        st_fetch: begin
          mem_valid <= 1'b1;
          mem_instr <= 1'b1;
          mem_wstrb <= '0;
          state <= st_fetch_wait;
        end
        st_fetch_wait: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            state <= st_decode;
          end
        end
        st_decode: begin
          state <= st_execute;
        end
        st_execute: begin
          // a faulting access is dropped before it reaches the port
          if (fault) begin
            trap <= 1'b1;
            state <= st_trap;
          end else begin
            pc <= ex.next_pc;
            if (is_mem) begin
              mem_valid <= 1'b1;
              mem_instr <= 1'b0;
              mem_wstrb <= req.wstrb;
              state <= st_mem;
            end else begin
              state <= st_write_back;
            end
          end
        end
        st_mem: begin
          if (mem_ready) begin
            mem_valid <= 1'b0;
            mem_wstrb <= '0;
            state <= st_write_back;
          end
        end
        st_write_back: begin
          state <= st_fetch;
        end
        default: begin
          state <= st_trap;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      st_fetch: begin
        mem_addr <= pc;
      end
      st_fetch_wait: begin
        if (mem_ready) begin
          instr_q <= mem_rdata;
        end
      end
      st_decode: begin
        dec_q <= dec;
      end
      st_execute: begin
        result_q <= ex.result;
        mem_addr <= req.addr;
        mem_wdata <= req.wdata;
      end
      st_mem: begin
        if (mem_ready && dec_q.is_load) begin
          result_q <= load_data;
        end
      end
      default: begin
      end
    endcase
  end

  // request stays put until memory takes it
  a_req_stable: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> mem_valid && $stable(mem_addr) && $stable(mem_wstrb)
      && $stable(mem_wdata))
    else $error("rv_core: memory request changed before mem_ready");

  a_trap_sticky: assert property (@(posedge clk) disable iff (reset)
    trap |=> trap && !mem_valid)
    else $error("rv_core: core left the trap or touched memory after it");

endmodule

/* include/tb_program.svh */
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

localparam logic [31:0] RESULT_BASE = 32'h0000_0400;
localparam logic [31:0] STROBE_BASE = 32'h0000_0600;
localparam logic [31:0] POISON_ADDR = 32'h0000_07f0;

logic [31:0] img [2][256];
int img_len [2];
logic [31:0] exp_res [2][32];
int exp_len [2];
logic [3:0] strb_exp [8];
logic [31:0] strb_data [8];
int strb_len;
int build_id;

function automatic logic [4:0] reg5(input int n);
  logic [31:0] v;
  v = n;
  return v[4:0];
endfunction

function automatic int here();
  return img_len[build_id] * 4;
endfunction

task automatic emit(input logic [31:0] w);
  img[build_id][img_len[build_id]] = w;
  img_len[build_id]++;
endtask

task automatic reg_op(input logic [6:0] f7, input logic [2:0] f3, input int rd, input int rs1,
                      input int rs2);
  emit({f7, reg5(rs2), reg5(rs1), f3, reg5(rd), rv_pkg::OPC_OP});
endtask

task automatic imm_op(input logic [2:0] f3, input int rd, input int rs1, input int imm);
  logic [31:0] v;
  v = imm;
  emit({v[11:0], reg5(rs1), f3, reg5(rd), rv_pkg::OPC_OP_IMM});
endtask

task automatic load_op(input logic [2:0] f3, input int rd, input int rs1, input int imm);
  logic [31:0] v;
  v = imm;
  emit({v[11:0], reg5(rs1), f3, reg5(rd), rv_pkg::OPC_LOAD});
endtask

task automatic store_op(input logic [2:0] f3, input int rs2, input int rs1, input int imm);
  logic [31:0] v;
  v = imm;
  emit({v[11:5], reg5(rs2), reg5(rs1), f3, v[4:0], rv_pkg::OPC_STORE});
endtask

task automatic branch_op(input logic [2:0] f3, input int rs1, input int rs2, input int off);
  logic [31:0] v;
  v = off;
  emit({v[12], v[10:5], reg5(rs2), reg5(rs1), f3, v[4:1], v[11], rv_pkg::OPC_BRANCH});
endtask

task automatic jal_op(input int rd, input int off);
  logic [31:0] v;
  v = off;
  emit({v[20], v[10:1], v[11], v[19:12], reg5(rd), rv_pkg::OPC_JAL});
endtask

task automatic jalr_op(input int rd, input int rs1, input int imm);
  logic [31:0] v;
  v = imm;
  emit({v[11:0], reg5(rs1), 3'b000, reg5(rd), rv_pkg::OPC_JALR});
endtask

task automatic upper_op(input logic [6:0] opc, input int rd, input int imm20);
  logic [31:0] v;
  v = imm20;
  emit({v[19:0], reg5(rd), opc});
endtask

// wrong-path marker, x29 holds the poison address
task automatic poison_op();
  store_op(3'b010, 2, 29, 0);
endtask

task automatic save_and_expect(input int rd, input logic [31:0] value);
  store_op(3'b010, rd, 31, exp_len[build_id] * 4);
  exp_res[build_id][exp_len[build_id]] = value;
  exp_len[build_id]++;
endtask

task automatic expect_strobe(input logic [3:0] strb, input logic [31:0] data);
  strb_exp[strb_len] = strb;
  strb_data[strb_len] = data;
  strb_len++;
endtask

// condition true then false, a wrong decision lands on the marker
task automatic branch_pair(input logic [2:0] f3, input int t1, input int t2, input int n1,
                           input int n2);
  branch_op(f3, t1, t2, 8);
  poison_op();
  branch_op(f3, n1, n2, 8);
  jal_op(0, 8);
  poison_op();
endtask

task automatic build_program_a();
  int a;
  build_id = 0;
  img_len[0] = 0;
  exp_len[0] = 0;
  strb_len = 0;
  imm_op(3'b000, 31, 0, 1024);
  imm_op(3'b000, 30, 0, 1536);
  imm_op(3'b000, 29, 0, 2032);
  imm_op(3'b000, 1, 0, -7);
  imm_op(3'b000, 2, 0, 5);
  reg_op(7'h00, 3'b000, 3, 1, 2);
  save_and_expect(3, 32'hffff_fffe);
  reg_op(7'h20, 3'b000, 3, 2, 1);
  save_and_expect(3, 32'h0000_000c);
  reg_op(7'h00, 3'b001, 3, 1, 2);
  save_and_expect(3, 32'hffff_ff20);
  reg_op(7'h00, 3'b101, 3, 1, 2);
  save_and_expect(3, 32'h07ff_ffff);
  reg_op(7'h20, 3'b101, 3, 1, 2);
  save_and_expect(3, 32'hffff_ffff);
  reg_op(7'h00, 3'b010, 3, 1, 2);
  save_and_expect(3, 32'h0000_0001);
  reg_op(7'h00, 3'b011, 3, 1, 2);
  save_and_expect(3, 32'h0000_0000);
  reg_op(7'h00, 3'b100, 3, 1, 2);
  save_and_expect(3, 32'hffff_fffc);
  reg_op(7'h00, 3'b110, 3, 1, 2);
  save_and_expect(3, 32'hffff_fffd);
  reg_op(7'h00, 3'b111, 3, 1, 2);
  save_and_expect(3, 32'h0000_0001);
  imm_op(3'b001, 3, 2, 3);
  save_and_expect(3, 32'h0000_0028);
  // srai carries 0100000 in the upper immediate bits
  imm_op(3'b101, 3, 1, 1024 + 1);
  save_and_expect(3, 32'hffff_fffc);
  imm_op(3'b010, 3, 1, -8);
  save_and_expect(3, 32'h0000_0000);
  imm_op(3'b011, 3, 2, -1);
  save_and_expect(3, 32'h0000_0001);
  imm_op(3'b100, 3, 2, 240);
  save_and_expect(3, 32'h0000_00f5);
  upper_op(rv_pkg::OPC_LUI, 3, 20'habcde);
  save_and_expect(3, 32'habcd_e000);
  a = here();
  upper_op(rv_pkg::OPC_AUIPC, 3, 1);
  save_and_expect(3, a + 32'h0000_1000);
  a = here();
  jal_op(4, 8);
  poison_op();
  save_and_expect(4, a + 4);
  a = here();
  imm_op(3'b000, 5, 0, a + 12);
  jalr_op(6, 5, 0);
  poison_op();
  save_and_expect(6, a + 8);
  // x1 = -7, x2 = 5
  branch_pair(3'b000, 2, 2, 1, 2);
  branch_pair(3'b001, 1, 2, 2, 2);
  branch_pair(3'b100, 1, 2, 2, 1);
  branch_pair(3'b101, 2, 1, 1, 2);
  branch_pair(3'b110, 2, 1, 1, 2);
  branch_pair(3'b111, 1, 2, 2, 1);
  store_op(3'b010, 0, 30, 0);
  expect_strobe(4'b1111, 32'h0000_0000);
  imm_op(3'b000, 7, 0, 128);
  store_op(3'b000, 7, 30, 0);
  expect_strobe(4'b0001, 32'h8080_8080);
  store_op(3'b000, 7, 30, 1);
  expect_strobe(4'b0010, 32'h8080_8080);
  store_op(3'b000, 7, 30, 2);
  expect_strobe(4'b0100, 32'h8080_8080);
  store_op(3'b000, 7, 30, 3);
  expect_strobe(4'b1000, 32'h8080_8080);
  load_op(3'b000, 8, 30, 0);
  save_and_expect(8, 32'hffff_ff80);
  load_op(3'b100, 8, 30, 1);
  save_and_expect(8, 32'h0000_0080);
  upper_op(rv_pkg::OPC_LUI, 9, 8);
  store_op(3'b001, 9, 30, 4);
  expect_strobe(4'b0011, 32'h8000_8000);
  store_op(3'b001, 9, 30, 6);
  expect_strobe(4'b1100, 32'h8000_8000);
  load_op(3'b001, 8, 30, 4);
  save_and_expect(8, 32'hffff_8000);
  load_op(3'b101, 8, 30, 6);
  save_and_expect(8, 32'h0000_8000);
  load_op(3'b010, 8, 30, 4);
  save_and_expect(8, 32'h8000_8000);
  // word store at offset 2 must trap
  store_op(3'b010, 2, 30, 2);
  poison_op();
endtask

task automatic build_program_b();
  build_id = 1;
  img_len[1] = 0;
  exp_len[1] = 0;
  imm_op(3'b000, 31, 0, 1024);
  imm_op(3'b000, 29, 0, 2032);
  imm_op(3'b000, 1, 0, 100);
  imm_op(3'b001, 2, 1, 4);
  save_and_expect(2, 32'h0000_0640);
  reg_op(7'h20, 3'b000, 3, 0, 1);
  save_and_expect(3, 32'hffff_ff9c);
  emit(32'h0000_0000);
  poison_op();
endtask

`endif

/* bench/tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;

  // fetch and data phases with three wait cycles each, plus the fixed states
  localparam int CPI_MAX = 14;

  logic clk;
  logic reset;
  logic mem_valid;
  logic mem_instr;
  logic mem_ready;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [3:0] mem_wstrb;
  logic [31:0] mem_rdata;
  logic trap;

  logic [31:0] mem [1024];
  logic [31:0] lfsr_state = 32'h6a4fa3bc;
  logic busy;
  logic [1:0] delay;
  logic bit_hi;
  logic bit_lo;
  int cycles;
  int cycle_limit;
  int error_count;
  int tests_passed;
  int tests_failed;
  int cur_id;
  int cur_len;
  int result_count;
  int strb_idx;
  int res_slot;
  logic handshake;
  logic in_result;
  logic in_strobe;
  logic expect_fetch;
  logic [31:0] res_exp;
  logic [3:0] strb_want;
  logic [31:0] data_want;
  logic [31:0] lane_mask;

  `include "tb_program.svh"

  rv_core u_rv_core (
    .clk       (clk),
    .reset     (reset),
    .mem_valid (mem_valid),
    .mem_instr (mem_instr),
    .mem_ready (mem_ready),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_wstrb (mem_wstrb),
    .mem_rdata (mem_rdata),
    .trap      (trap)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    lfsr_state = lfsr_step(lfsr_state);
    b = lfsr_state[0];
  endtask

  task automatic install_image(input int id);
    for (int k = 0; k < 1024; k++) begin
      mem[k] = 32'ha5a5_0000 ^ (k * 32'h0001_0003);
    end
    for (int k = 0; k < img_len[id]; k++) begin
      mem[k] = img[id][k];
    end
  endtask

  // memory answers each request after 0 to 3 random wait cycles
  initial begin
    mem_ready = 1'b0;
    mem_rdata = '0;
    busy = 1'b0;
    delay = 2'd0;
    forever begin
      @(posedge clk);
      if (reset) begin
        busy = 1'b0;
        #1;
        mem_ready = 1'b0;
      end else if (mem_ready) begin
        for (int i = 0; i < 4; i++) begin
          if (mem_wstrb[i]) begin
            mem[mem_addr[11:2]][8*i +: 8] = mem_wdata[8*i +: 8];
          end
        end
        #1;
        mem_ready = 1'b0;
      end else if (mem_valid) begin
        if (!busy) begin
          busy = 1'b1;
          take_bit(bit_hi);
          take_bit(bit_lo);
          delay = {bit_hi, bit_lo};
        end
        if (delay == 2'd0) begin
          busy = 1'b0;
          #1;
          mem_ready = 1'b1;
          mem_rdata = mem[mem_addr[11:2]];
        end else begin
          delay = delay - 2'd1;
        end
      end
    end
  end

  assign handshake = mem_valid && mem_ready;
  assign in_result = mem_addr[31:7] == RESULT_BASE[31:7];
  assign in_strobe = mem_addr[31:3] == STROBE_BASE[31:3];
  assign res_slot = int'(mem_addr[6:2]);
  assign res_exp = exp_res[cur_id][res_slot];
  assign cur_len = exp_len[cur_id];
  assign strb_want = strb_exp[strb_idx % 8];
  assign data_want = strb_data[strb_idx % 8];
  assign lane_mask = {{8{strb_want[3]}}, {8{strb_want[2]}}, {8{strb_want[1]}}, {8{strb_want[0]}}};

  always @(posedge clk) begin
    if (reset) begin
      result_count <= 0;
      strb_idx <= 0;
    end else if (handshake && mem_wstrb != 4'b0000) begin
      if (in_result) begin
        result_count <= result_count + 1;
      end
      if (in_strobe) begin
        strb_idx <= strb_idx + 1;
      end
    end
  end

  // each instruction starts with a fetch, a load or store adds one data request
  always @(posedge clk) begin
    if (reset) begin
      expect_fetch <= 1'b1;
    end else if (handshake) begin
      if (expect_fetch) begin
        expect_fetch <= !(mem_rdata[6:0] == rv_pkg::OPC_LOAD
                          || mem_rdata[6:0] == rv_pkg::OPC_STORE);
      end else begin
        expect_fetch <= 1'b1;
      end
    end
  end

  a_result_slot: assert property (@(posedge clk) disable iff (reset)
    handshake && mem_wstrb != 4'b0000 && in_result |-> res_slot < cur_len)
    else begin
      $display("result store to an address past the expected table at %0t", $time);
      error_count++;
    end

  a_result_value: assert property (@(posedge clk) disable iff (reset)
    handshake && mem_wstrb != 4'b0000 && in_result && res_slot < cur_len
      |-> mem_wdata == res_exp)
    else begin
      $display("** Error at %0t: mem_wdata = %h, expected %h", $time, $sampled(mem_wdata),
               $sampled(res_exp));
      error_count++;
    end

  a_strobe: assert property (@(posedge clk) disable iff (reset)
    handshake && mem_wstrb != 4'b0000 && in_strobe |-> strb_idx < strb_len
      && mem_wstrb == strb_want)
    else begin
      $display("** Error at %0t: mem_wstrb = %b, expected %b", $time, $sampled(mem_wstrb),
               $sampled(strb_want));
      error_count++;
    end

  a_lane: assert property (@(posedge clk) disable iff (reset)
    handshake && mem_wstrb != 4'b0000 && in_strobe
      |-> (mem_wdata & lane_mask) == (data_want & lane_mask))
    else begin
      $display("** Error at %0t: mem_wdata = %h, expected %h", $time, $sampled(mem_wdata),
               $sampled(data_want));
      error_count++;
    end

  a_poison: assert property (@(posedge clk) disable iff (reset)
    !(mem_valid && mem_wstrb != 4'b0000 && mem_addr == POISON_ADDR))
    else begin
      $display("wrong path taken, marker address written at %0t", $time);
      error_count++;
    end

  a_instr_flag: assert property (@(posedge clk) disable iff (reset)
    mem_valid |-> mem_instr == expect_fetch)
    else begin
      $display("** Error at %0t: mem_instr = %b, expected %b", $time, $sampled(mem_instr),
               $sampled(expect_fetch));
      error_count++;
    end

  a_fetch: assert property (@(posedge clk) disable iff (reset)
    mem_valid && mem_instr |-> mem_wstrb == 4'b0000 && mem_addr[1:0] == 2'b00)
    else begin
      $display("fetch with a strobe or an unaligned address at %0t", $time);
      error_count++;
    end

  a_hold: assert property (@(posedge clk) disable iff (reset)
    mem_valid && !mem_ready |=> $stable(mem_addr) && $stable(mem_wstrb) && $stable(mem_wdata))
    else begin
      $display("request changed while waiting for mem_ready at %0t", $time);
      error_count++;
    end

  a_reset_idle: assert property (@(posedge clk) $fell(reset) |-> !mem_valid && !trap)
    else begin
      $display("mem_valid or trap high right after reset at %0t", $time);
      error_count++;
    end

  a_trap_quiet: assert property (@(posedge clk) disable iff (reset)
    trap |-> !mem_valid ##1 trap)
    else begin
      $display("trap dropped or memory accessed after the trap at %0t", $time);
      error_count++;
    end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles, trap never reached", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic run_program(input int id, input string name);
    int errors_before;
    errors_before = error_count;
    #1;
    reset = 1'b1;
    cur_id = id;
    install_image(id);
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    while (!trap) @(posedge clk);
    // let the quiet-after-trap checks run for a while
    repeat (20) @(posedge clk);
    if (result_count != exp_len[id]) begin
      $display("** Error at %0t: result_count = %0d, expected %0d in %s", $time,
               result_count, exp_len[id], name);
      error_count++;
    end
    if (error_count == errors_before) begin
      tests_passed++;
      $display("test %s: trap reached, results correct", name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", name, error_count - errors_before);
    end
  endtask

  initial begin
    reset = 1'b1;
    cycles = 0;
    error_count = 0;
    tests_passed = 0;
    tests_failed = 0;
    cur_id = 0;
    build_program_a();
    build_program_b();
    cycle_limit = 8 * (img_len[0] + img_len[1]) * CPI_MAX;
    run_program(0, "program_a");
    run_program(1, "program_b");
    $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
             error_count);
    if (tests_failed == 0 && error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* src.f */
+incdir+include
logic/rv_pkg.sv
logic/rv_decode.sv
logic/rv_alu.sv
logic/rv_regfile.sv
logic/rv_lsu.sv
logic/rv_core.sv
bench/tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
LINTFLAGS = --lint-only --timing --assert
TOP       = tb_rv_core
FILELIST  = src.f
BUILD     = obj_dir
LOG       = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
